//--- video_pkg.sv
// raster sizes are tiny simulation values; one clock domain only; palette windows are write-only
`default_nettype none

package video_pkg;

    // raster, in clocks and lines
    localparam int h_active     = 16;
    localparam int h_total      = 24;
    localparam int h_sync_start = 18;
    localparam int h_sync_end   = 20;
    localparam int v_active     = 6;
    localparam int v_total      = 9;
    // vsync is high for this one line only
    localparam int v_sync_line  = 7;

    // axi4-lite geometry
    localparam int axi_addr_w = 8;
    localparam int axi_data_w = 32;

    // register map
    localparam logic [axi_addr_w-1:0] reg_ctrl_addr  = 8'h00;
    localparam logic [axi_addr_w-1:0] reg_frame_addr = 8'h04;
    // 16 word-aligned entries per palette
    localparam logic [axi_addr_w-1:0] pal_a_base     = 8'h40;
    localparam logic [axi_addr_w-1:0] pal_b_base     = 8'h80;

    // response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    typedef struct packed {
        logic [3:0] alpha;
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } argb_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // value 3 is reserved, the blender treats it as opaque
    typedef enum logic [1:0] {
        blend_opaque = 2'd0,
        blend_key    = 2'd1,
        blend_alpha  = 2'd2
    } blend_mode_e;

    typedef struct packed {
        logic        enable;
        blend_mode_e mode;
    } ctrl_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } vid_sync_t;

    // at most one of we_a / we_b set
    typedef struct packed {
        logic       we_a;
        logic       we_b;
        logic [3:0] index;
        argb_t      color;
    } pal_wr_t;

endpackage

`default_nettype wire

//--- video_ctrl.sv
// single outstanding write and read; control at 0x00 is {mode[2:1], enable[0]}; palette reads give 0
`default_nettype none

module video_ctrl (
    input  wire logic                                 clk,
    input  wire logic                                 arst_n_i,
    // write address and data
    input  wire logic [video_pkg::axi_addr_w-1:0]     awaddr_i,
    input  wire logic                                 awvalid_i,
    output logic                                      awready_o,
    input  wire logic [video_pkg::axi_data_w-1:0]     wdata_i,
    input  wire logic [video_pkg::axi_data_w/8-1:0]   wstrb_i,
    input  wire logic                                 wvalid_i,
    output logic                                      wready_o,
    // write response
    output logic [1:0]                                bresp_o,
    output logic                                      bvalid_o,
    input  wire logic                                 bready_i,
    // read address and data
    input  wire logic [video_pkg::axi_addr_w-1:0]     araddr_i,
    input  wire logic                                 arvalid_i,
    output logic                                      arready_o,
    output logic [video_pkg::axi_data_w-1:0]          rdata_o,
    output logic [1:0]                                rresp_o,
    output logic                                      rvalid_o,
    input  wire logic                                 rready_i,
    // video side
    input  wire logic                                 frame_start_i,
    output video_pkg::ctrl_t                          ctrl_o,
    output video_pkg::pal_wr_t                        pal_wr_o
);

    typedef enum logic {
        w_idle,
        w_resp
    } wr_state_e;

    typedef enum logic {
        r_idle,
        r_resp
    } rd_state_e;

    wr_state_e   wr_state;
    rd_state_e   rd_state;
    logic        wr_hs;
    logic        rd_hs;
    logic [15:0] frame_cnt;

    // palette window match, word aligned only
    function automatic logic in_pal(input logic [video_pkg::axi_addr_w-1:0] addr,
                                    input logic [video_pkg::axi_addr_w-1:0] base);
        return (addr[7:6] == base[7:6]) && (addr[1:0] == 2'b00);
    endfunction

    function automatic logic is_mapped(input logic [video_pkg::axi_addr_w-1:0] addr);
        return (addr == video_pkg::reg_ctrl_addr) || (addr == video_pkg::reg_frame_addr) ||
               in_pal(addr, video_pkg::pal_a_base) || in_pal(addr, video_pkg::pal_b_base);
    endfunction

    // accept only with both channels valid and no response pending
    assign wr_hs     = (wr_state == w_idle) && awvalid_i && wvalid_i;
    assign awready_o = wr_hs;
    assign wready_o  = wr_hs;
    assign bvalid_o  = (wr_state == w_resp);

    assign rd_hs     = (rd_state == r_idle) && arvalid_i;
    assign arready_o = rd_hs;
    assign rvalid_o  = (rd_state == r_resp);

    // palette write goes out in the handshake cycle
    // entry is 16 bits, so both low strobes are required
    always_comb begin
        pal_wr_o       = '0;
        pal_wr_o.index = awaddr_i[5:2];
        pal_wr_o.color = video_pkg::argb_t'(wdata_i[15:0]);
        pal_wr_o.we_a  = wr_hs && (&wstrb_i[1:0]) && in_pal(awaddr_i, video_pkg::pal_a_base);
        pal_wr_o.we_b  = wr_hs && (&wstrb_i[1:0]) && in_pal(awaddr_i, video_pkg::pal_b_base);
    end

    // handshake fsms
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_state <= w_idle;
            rd_state <= r_idle;
        end else begin
            if (wr_hs) begin
                wr_state <= w_resp;
            end else if (bvalid_o && bready_i) begin
                wr_state <= w_idle;
            end
            if (rd_hs) begin
                rd_state <= r_resp;
            end else if (rvalid_o && rready_i) begin
                rd_state <= r_idle;
            end
        end
    end

    // control register and frame counter
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_o    <= '{enable: 1'b0, mode: video_pkg::blend_opaque};
            frame_cnt <= '0;
        end else begin
            if (wr_hs && wstrb_i[0] && (awaddr_i == video_pkg::reg_ctrl_addr)) begin
                ctrl_o.enable <= wdata_i[0];
                ctrl_o.mode   <= video_pkg::blend_mode_e'(wdata_i[2:1]);
            end
            // wraps at 16 bits
            if (frame_start_i) begin
                frame_cnt <= frame_cnt + 16'd1;
            end
        end
    end

    // response payload, only looked at while valid
    always_ff @(posedge clk) begin
        if (wr_hs) begin
            bresp_o <= is_mapped(awaddr_i) ? video_pkg::resp_okay : video_pkg::resp_slverr;
        end
        if (rd_hs) begin
            rresp_o <= is_mapped(araddr_i) ? video_pkg::resp_okay : video_pkg::resp_slverr;
            if (araddr_i == video_pkg::reg_ctrl_addr) begin
                rdata_o <= video_pkg::axi_data_w'({ctrl_o.mode, ctrl_o.enable});
            end else if (araddr_i == video_pkg::reg_frame_addr) begin
                rdata_o <= video_pkg::axi_data_w'(frame_cnt);
            end else begin
                // palettes and holes read as zero
                rdata_o <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- video_timing.sv
// outputs registered; counters held at zero and sync low while disabled; first pixel one cycle after enable
`default_nettype none

module video_timing (
    input  wire logic               clk,
    input  wire logic               arst_n_i,
    input  wire video_pkg::ctrl_t   ctrl_i,
    output video_pkg::vid_sync_t    sync_o,
    output logic                    frame_start_o
);

    logic [$clog2(video_pkg::h_total)-1:0] h_cnt;
    logic [$clog2(video_pkg::v_total)-1:0] v_cnt;
    logic                                  h_last;
    logic                                  v_last;
    video_pkg::vid_sync_t                  sync_next;

    assign h_last = (h_cnt == video_pkg::h_total - 1);
    assign v_last = (v_cnt == video_pkg::v_total - 1);

    // decode current position, registered below
    always_comb begin
        sync_next.de    = (h_cnt < video_pkg::h_active) && (v_cnt < video_pkg::v_active);
        sync_next.hsync = (h_cnt >= video_pkg::h_sync_start) && (h_cnt < video_pkg::h_sync_end);
        sync_next.vsync = (v_cnt == video_pkg::v_sync_line);
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            h_cnt         <= '0;
            v_cnt         <= '0;
            sync_o        <= '0;
            frame_start_o <= 1'b0;
        end else if (!ctrl_i.enable) begin
            // parked at top left
            h_cnt         <= '0;
            v_cnt         <= '0;
            sync_o        <= '0;
            frame_start_o <= 1'b0;
        end else begin
            sync_o        <= sync_next;
            // rising edge of vsync
            frame_start_o <= sync_next.vsync && !sync_o.vsync;
            if (h_last) begin
                h_cnt <= '0;
                v_cnt <= v_last ? '0 : v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- palette_lookup.sv
// storage has no reset and is write-only from the bus; read data lags the index by one cycle
`default_nettype none

module palette_lookup (
    input  wire logic               clk,
    input  wire video_pkg::pal_wr_t pal_wr_i,
    input  wire logic [3:0]         index_a_i,
    input  wire logic [3:0]         index_b_i,
    output video_pkg::argb_t        colour_a_o,
    output video_pkg::argb_t        colour_b_o
);

    // one array per playfield
    video_pkg::argb_t pal_a [16];
    video_pkg::argb_t pal_b [16];

    // shared write port
    always_ff @(posedge clk) begin
        if (pal_wr_i.we_a) begin
            pal_a[pal_wr_i.index] <= pal_wr_i.color;
        end
        if (pal_wr_i.we_b) begin
            pal_b[pal_wr_i.index] <= pal_wr_i.color;
        end
    end

    // registered reads, ram style
    always_ff @(posedge clk) begin
        colour_a_o <= pal_a[index_a_i];
        colour_b_o <= pal_b[index_b_i];
    end

endmodule

`default_nettype wire

//--- video_blend.sv
// expects colours one cycle behind sync; mode is pipelined with sync; colour is zero outside de
`default_nettype none

module video_blend (
    input  wire logic                   clk,
    input  wire logic                   arst_n_i,
    input  wire video_pkg::ctrl_t       ctrl_i,
    input  wire video_pkg::vid_sync_t   sync_i,
    input  wire video_pkg::argb_t       colour_a_i,
    input  wire video_pkg::argb_t       colour_b_i,
    output video_pkg::rgb_t             blend_rgb_o,
    output video_pkg::vid_sync_t        sync_o
);

    video_pkg::vid_sync_t   sync_d1;
    video_pkg::blend_mode_e mode_d1;
    video_pkg::rgb_t        rgb_a;
    video_pkg::rgb_t        rgb_b;
    video_pkg::rgb_t        mix_rgb;

    // one channel of ((a+1)*top + (16-a)*bottom) >> 4
    // sum peaks at 255, so 8 bits hold it
    function automatic logic [3:0] mix(input logic [3:0] alpha,
                                       input logic [3:0] top,
                                       input logic [3:0] bottom);
        logic [7:0] sum;
        sum = (8'(alpha) + 8'd1) * 8'(top) + (8'd16 - 8'(alpha)) * 8'(bottom);
        return sum[7:4];
    endfunction

    assign rgb_a = {colour_a_i.red, colour_a_i.green, colour_a_i.blue};
    assign rgb_b = {colour_b_i.red, colour_b_i.green, colour_b_i.blue};

    // a is bottom layer, b on top
    always_comb begin
        case (mode_d1)
            video_pkg::blend_key: begin
                // b wins only with its alpha msb set and a's clear
                mix_rgb = (colour_b_i.alpha[3] && !colour_a_i.alpha[3]) ? rgb_b : rgb_a;
            end
            video_pkg::blend_alpha: begin
                mix_rgb.red   = mix(colour_b_i.alpha, colour_b_i.red, colour_a_i.red);
                mix_rgb.green = mix(colour_b_i.alpha, colour_b_i.green, colour_a_i.green);
                mix_rgb.blue  = mix(colour_b_i.alpha, colour_b_i.blue, colour_a_i.blue);
            end
            // opaque and reserved
            default: mix_rgb = rgb_a;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_d1     <= '0;
            mode_d1     <= video_pkg::blend_opaque;
            sync_o      <= '0;
            blend_rgb_o <= '0;
        end else begin
            // stage 1 matches palette read latency
            sync_d1     <= sync_i;
            mode_d1     <= ctrl_i.mode;
            // stage 2 output
            sync_o      <= sync_d1;
            blend_rgb_o <= sync_d1.de ? mix_rgb : '0;
        end
    end

endmodule

`default_nettype wire

//--- video_compositor_top.sv
// pixel request to rgb_o is two cycles; indices must be valid while pix_req_o is high; no back-pressure
`default_nettype none

module video_compositor_top (
    input  wire logic                                 clk,
    input  wire logic                                 arst_n_i,
    // axi4-lite slave
    input  wire logic [video_pkg::axi_addr_w-1:0]     awaddr_i,
    input  wire logic                                 awvalid_i,
    output logic                                      awready_o,
    input  wire logic [video_pkg::axi_data_w-1:0]     wdata_i,
    input  wire logic [video_pkg::axi_data_w/8-1:0]   wstrb_i,
    input  wire logic                                 wvalid_i,
    output logic                                      wready_o,
    output logic [1:0]                                bresp_o,
    output logic                                      bvalid_o,
    input  wire logic                                 bready_i,
    input  wire logic [video_pkg::axi_addr_w-1:0]     araddr_i,
    input  wire logic                                 arvalid_i,
    output logic                                      arready_o,
    output logic [video_pkg::axi_data_w-1:0]          rdata_o,
    output logic [1:0]                                rresp_o,
    output logic                                      rvalid_o,
    input  wire logic                                 rready_i,
    // playfield indices from the fetcher
    input  wire logic [3:0]                           pf_a_index_i,
    input  wire logic [3:0]                           pf_b_index_i,
    // video out
    output logic                                      pix_req_o,
    output logic                                      hsync_o,
    output logic                                      vsync_o,
    output logic                                      de_o,
    output video_pkg::rgb_t                           rgb_o
);

    video_pkg::ctrl_t     ctrl;
    video_pkg::pal_wr_t   pal_wr;
    video_pkg::vid_sync_t sync;
    video_pkg::vid_sync_t sync_out;
    video_pkg::argb_t     colour_a;
    video_pkg::argb_t     colour_b;
    logic                 frame_start;

    video_ctrl video_ctrl_inst (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .awaddr_i      (awaddr_i),
        .awvalid_i     (awvalid_i),
        .awready_o     (awready_o),
        .wdata_i       (wdata_i),
        .wstrb_i       (wstrb_i),
        .wvalid_i      (wvalid_i),
        .wready_o      (wready_o),
        .bresp_o       (bresp_o),
        .bvalid_o      (bvalid_o),
        .bready_i      (bready_i),
        .araddr_i      (araddr_i),
        .arvalid_i     (arvalid_i),
        .arready_o     (arready_o),
        .rdata_o       (rdata_o),
        .rresp_o       (rresp_o),
        .rvalid_o      (rvalid_o),
        .rready_i      (rready_i),
        .frame_start_i (frame_start),
        .ctrl_o        (ctrl),
        .pal_wr_o      (pal_wr)
    );

    video_timing video_timing_inst (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .ctrl_i        (ctrl),
        .sync_o        (sync),
        .frame_start_o (frame_start)
    );

    palette_lookup palette_lookup_inst (
        .clk        (clk),
        .pal_wr_i   (pal_wr),
        .index_a_i  (pf_a_index_i),
        .index_b_i  (pf_b_index_i),
        .colour_a_o (colour_a),
        .colour_b_o (colour_b)
    );

    video_blend video_blend_inst (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .ctrl_i      (ctrl),
        .sync_i      (sync),
        .colour_a_i  (colour_a),
        .colour_b_i  (colour_b),
        .blend_rgb_o (rgb_o),
        .sync_o      (sync_out)
    );

    // request indices during active display
    assign pix_req_o = sync.de;
    assign hsync_o   = sync_out.hsync;
    assign vsync_o   = sync_out.vsync;
    assign de_o      = sync_out.de;

endmodule

`default_nettype wire

//--- video_compositor_properties.sv
// shadows bus writes with full strobes only; expects palettes to change only while video is off
`default_nettype none

module video_compositor_properties (
    input wire logic            clk,
    input wire logic            arst_n_i,
    input wire logic [7:0]      awaddr_i,
    input wire logic            awvalid_i,
    input wire logic            awready_o,
    input wire logic [31:0]     wdata_i,
    input wire logic [3:0]      wstrb_i,
    input wire logic            wvalid_i,
    input wire logic            wready_o,
    input wire logic [1:0]      bresp_o,
    input wire logic            bvalid_o,
    input wire logic            bready_i,
    input wire logic [31:0]     rdata_o,
    input wire logic [1:0]      rresp_o,
    input wire logic            rvalid_o,
    input wire logic            rready_i,
    input wire logic [3:0]      pf_a_index_i,
    input wire logic [3:0]      pf_b_index_i,
    input wire logic            pix_req_o,
    input wire logic            hsync_o,
    input wire logic            vsync_o,
    input wire logic            de_o,
    input wire video_pkg::rgb_t rgb_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int               fail_count = 0;
    logic             wr_done;
    logic             sh_enable;
    logic [1:0]       sh_mode;
    video_pkg::argb_t sh_pal_a [16];
    video_pkg::argb_t sh_pal_b [16];
    logic [3:0]       idx_a_d1;
    logic [3:0]       idx_a_d2;
    logic [3:0]       idx_b_d1;
    logic [3:0]       idx_b_d2;
    logic [1:0]       mode_d1;
    logic [1:0]       mode_d2;
    video_pkg::argb_t col_a;
    video_pkg::argb_t col_b;
    video_pkg::rgb_t  exp_rgb;

    // weighted sum per channel, b over a
    function automatic logic [3:0] weigh(input int ab, input int top, input int bot);
        return 4'(((ab + 1) * top + (16 - ab) * bot) >> 4);
    endfunction

    assign wr_done = awvalid_i && awready_o && wvalid_i && wready_o;

    // shadow control register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sh_enable <= 1'b0;
            sh_mode   <= 2'd0;
        end else if (wr_done && wstrb_i[0] && awaddr_i == 8'h00) begin
            sh_enable <= wdata_i[0];
            sh_mode   <= wdata_i[2:1];
        end
    end

    // shadow palettes, word aligned windows at 0x40 and 0x80
    always_ff @(posedge clk) begin
        if (wr_done && wstrb_i[1:0] == 2'b11 && awaddr_i[1:0] == 2'b00) begin
            if (awaddr_i[7:6] == 2'b01) sh_pal_a[awaddr_i[5:2]] <= wdata_i[15:0];
            if (awaddr_i[7:6] == 2'b10) sh_pal_b[awaddr_i[5:2]] <= wdata_i[15:0];
        end
    end

    // two cycles from request to pixel
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            idx_a_d1 <= '0;
            idx_a_d2 <= '0;
            idx_b_d1 <= '0;
            idx_b_d2 <= '0;
            mode_d1  <= '0;
            mode_d2  <= '0;
        end else begin
            idx_a_d1 <= pf_a_index_i;
            idx_a_d2 <= idx_a_d1;
            idx_b_d1 <= pf_b_index_i;
            idx_b_d2 <= idx_b_d1;
            mode_d1  <= sh_mode;
            mode_d2  <= mode_d1;
        end
    end

    // predicted pixel; reserved mode falls back to a
    always_comb begin
        col_a   = sh_pal_a[idx_a_d2];
        col_b   = sh_pal_b[idx_b_d2];
        exp_rgb = {col_a.red, col_a.green, col_a.blue};
        if (mode_d2 == video_pkg::blend_key && col_b.alpha[3] && !col_a.alpha[3]) begin
            exp_rgb = {col_b.red, col_b.green, col_b.blue};
        end else if (mode_d2 == video_pkg::blend_alpha) begin
            exp_rgb.red   = weigh(col_b.alpha, col_b.red, col_a.red);
            exp_rgb.green = weigh(col_b.alpha, col_b.green, col_a.green);
            exp_rgb.blue  = weigh(col_b.alpha, col_b.blue, col_a.blue);
        end
    end

    bresp_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
        else begin
            $error("bvalid or bresp changed before bready");
            fail_count = fail_count + 1;
        end

    rresp_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o))
        else begin
            $error("rvalid, rdata or rresp changed before rready");
            fail_count = fail_count + 1;
        end

    pixel_colour: assert property (@(posedge clk) disable iff (!arst_n_i)
        de_o |-> rgb_o == exp_rgb)
        else begin
            $error("rgb_o %h, predicted %h", rgb_o, exp_rgb);
            fail_count = fail_count + 1;
        end

    blank_black: assert property (@(posedge clk) disable iff (!arst_n_i)
        !de_o |-> rgb_o == '0)
        else begin
            $error("rgb_o not zero outside de_o");
            fail_count = fail_count + 1;
        end

    // request stops one cycle after enable drops, outputs three cycles after
    off_no_req: assert property (@(posedge clk) disable iff (!arst_n_i)
        !$past(sh_enable) |-> !pix_req_o)
        else begin
            $error("pix_req_o high while disabled");
            fail_count = fail_count + 1;
        end

    off_quiet: assert property (@(posedge clk) disable iff (!arst_n_i)
        !$past(sh_enable, 3) |-> !de_o && !hsync_o && !vsync_o)
        else begin
            $error("sync or de_o active while disabled");
            fail_count = fail_count + 1;
        end

endmodule

bind video_compositor_top video_compositor_properties video_compositor_properties_inst (.*);

`default_nettype wire

//--- tb_video_compositor.sv
// checking lives in the bound assertions; stops at the first error; timeouts are in clock cycles
`default_nettype none

module tb_video_compositor;
    timeunit 1ns;
    timeprecision 1ps;

    logic                                 clk;
    logic                                 arst_n_i;
    logic [video_pkg::axi_addr_w-1:0]     awaddr_i;
    logic                                 awvalid_i;
    logic                                 awready_o;
    logic [video_pkg::axi_data_w-1:0]     wdata_i;
    logic [video_pkg::axi_data_w/8-1:0]   wstrb_i;
    logic                                 wvalid_i;
    logic                                 wready_o;
    logic [1:0]                           bresp_o;
    logic                                 bvalid_o;
    logic                                 bready_i;
    logic [video_pkg::axi_addr_w-1:0]     araddr_i;
    logic                                 arvalid_i;
    logic                                 arready_o;
    logic [video_pkg::axi_data_w-1:0]     rdata_o;
    logic [1:0]                           rresp_o;
    logic                                 rvalid_o;
    logic                                 rready_i;
    logic [3:0]                           pf_a_index_i;
    logic [3:0]                           pf_b_index_i;
    logic                                 pix_req_o;
    logic                                 hsync_o;
    logic                                 vsync_o;
    logic                                 de_o;
    video_pkg::rgb_t                      rgb_o;

    video_compositor_top video_compositor_top_inst (.*);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        stop_run();
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    // inputs change 2 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        int stall;
        awaddr_i  = addr;
        wdata_i   = data;
        wstrb_i   = 4'hf;
        awvalid_i = 1'b1;
        wvalid_i  = 1'b1;
        n = 0;
        @(negedge clk);
        while (!(awready_o && wready_o)) begin
            n++;
            if (n > 100) timed_out("awready/wready");
            @(negedge clk);
        end
        next_cycle();
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
        // hold off bready a little, response must stay put
        stall = $urandom_range(2);
        repeat (stall) next_cycle();
        bready_i = 1'b1;
        n = 0;
        @(negedge clk);
        while (!bvalid_o) begin
            n++;
            if (n > 100) timed_out("bvalid");
            @(negedge clk);
        end
        resp = bresp_o;
        next_cycle();
        bready_i = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        int stall;
        araddr_i  = addr;
        arvalid_i = 1'b1;
        n = 0;
        @(negedge clk);
        while (!arready_o) begin
            n++;
            if (n > 100) timed_out("arready");
            @(negedge clk);
        end
        next_cycle();
        arvalid_i = 1'b0;
        stall = $urandom_range(2);
        repeat (stall) next_cycle();
        rready_i = 1'b1;
        n = 0;
        @(negedge clk);
        while (!rvalid_o) begin
            n++;
            if (n > 100) timed_out("rvalid");
            @(negedge clk);
        end
        data = rdata_o;
        resp = rresp_o;
        next_cycle();
        rready_i = 1'b0;
    endtask

    // enable one mode for two frames, frame counter must move by two
    task automatic run_mode(input video_pkg::blend_mode_e mode);
        logic [31:0] f0;
        logic [31:0] f1;
        logic [1:0]  resp;
        logic        prev;
        int          edges;
        int          n;
        axi_read(video_pkg::reg_frame_addr, f0, resp);
        axi_write(video_pkg::reg_ctrl_addr, 32'({mode, 1'b1}), resp);
        prev  = vsync_o;
        edges = 0;
        n     = 0;
        while (edges < 2) begin
            @(negedge clk);
            n++;
            if (n > 1000) timed_out("two vsync_o rising edges");
            if (vsync_o && !prev) edges++;
            prev = vsync_o;
        end
        // back to the drive point just after the edge
        next_cycle();
        axi_read(video_pkg::reg_frame_addr, f1, resp);
        check_value("frame counter", f1, {16'h0, f0[15:0] + 16'd2});
        axi_write(video_pkg::reg_ctrl_addr, 32'({mode, 1'b0}), resp);
    endtask

    // new index pair only outside active requests
    always @(posedge clk) begin
        #2;
        if (!pix_req_o) begin
            pf_a_index_i = 4'($urandom);
            pf_b_index_i = 4'($urandom);
        end
    end

    // any bound assertion failure ends the run
    always @(negedge clk) begin
        if (video_compositor_top_inst.video_compositor_properties_inst.fail_count != 0) begin
            $display("a bound assertion failed, see the error above");
            stop_run();
        end
    end

    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        void'($urandom(32'hbd448cc0));
        arst_n_i     = 1'b0;
        awaddr_i     = '0;
        awvalid_i    = 1'b0;
        wdata_i      = '0;
        wstrb_i      = '0;
        wvalid_i     = 1'b0;
        bready_i     = 1'b0;
        araddr_i     = '0;
        arvalid_i    = 1'b0;
        rready_i     = 1'b0;
        pf_a_index_i = '0;
        pf_b_index_i = '0;
        repeat (5) @(posedge clk);
        #2;
        arst_n_i = 1'b1;
        next_cycle();

        // control readback, alpha mode while disabled
        axi_write(video_pkg::reg_ctrl_addr, 32'h4, resp);
        check_value("control write response", 32'(resp), 32'(video_pkg::resp_okay));
        axi_read(video_pkg::reg_ctrl_addr, data, resp);
        check_value("control readback", data, 32'h4);
        check_value("control read response", 32'(resp), 32'(video_pkg::resp_okay));
        // holes answer slverr
        axi_write(8'h08, 32'h1, resp);
        check_value("unmapped write response", 32'(resp), 32'(video_pkg::resp_slverr));
        axi_read(8'hc0, data, resp);
        check_value("unmapped read response", 32'(resp), 32'(video_pkg::resp_slverr));
        // palettes are write-only
        axi_read(8'h44, data, resp);
        check_value("palette readback", data, 32'h0);
        axi_write(video_pkg::reg_ctrl_addr, 32'h0, resp);

        // random palettes while video is off
        for (int i = 0; i < 16; i++) begin
            axi_write(video_pkg::pal_a_base + 8'(4 * i), 32'($urandom) & 32'hffff, resp);
            check_value("palette a write response", 32'(resp), 32'(video_pkg::resp_okay));
            axi_write(video_pkg::pal_b_base + 8'(4 * i), 32'($urandom) & 32'hffff, resp);
            check_value("palette b write response", 32'(resp), 32'(video_pkg::resp_okay));
        end

        run_mode(video_pkg::blend_opaque);
        run_mode(video_pkg::blend_key);
        run_mode(video_pkg::blend_alpha);
        repeat (10) next_cycle();

        if (video_compositor_top_inst.video_compositor_properties_inst.fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("a bound assertion failed during the run");
            stop_run();
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
video_pkg.sv
video_ctrl.sv
video_timing.sv
palette_lookup.sv
video_blend.sv
video_compositor_top.sv
video_compositor_properties.sv
tb_video_compositor.sv
